// File: verilog/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

////////////////////////////////////////
// Data path width
////////////////////////////////////////

`define CACHE_WORD_BITS 16 // Core word and byte address width

////////////////////////////////////////
// Address split, tag | index | offset | byte
////////////////////////////////////////

`define CACHE_TAG_BITS 7 // Upper address bits kept per set
`define CACHE_INDEX_BITS 5 // Selects one of the sets
`define CACHE_OFFSET_BITS 3 // Word within a block, bit 0 dropped

////////////////////////////////////////
// Array geometry
////////////////////////////////////////

`define CACHE_SETS 32 // 2**CACHE_INDEX_BITS
`define CACHE_BLOCK_WORDS 8 // 2**CACHE_OFFSET_BITS, also words per fill

`endif

// File: verilog/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    // Byte address from the core, also used toward DRAM
    typedef logic [`CACHE_WORD_BITS-1:0] addr_t;

    // One data word, core side and DRAM side
    typedef logic [`CACHE_WORD_BITS-1:0] word_t;

    typedef logic [`CACHE_TAG_BITS-1:0] tag_t; // Tag field of the address
    typedef logic [`CACHE_INDEX_BITS-1:0] index_t; // Set select
    typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t; // Word select inside a block

    // Stored tag entry, valid bit on top of the tag
    typedef logic [`CACHE_TAG_BITS:0] tag_entry_t;

    ////////////////////////////////////////
    // Fill FSM
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        fill_idle, // Serving the core from the arrays
        fill_request, // Issuing word requests to DRAM
        fill_wait, // All requests out, collecting returns
        fill_tag // Block complete, tag entry written
    } fill_state_t;

endpackage

// File: verilog/cache_data_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

// Word storage of the cache, one row of words per set
module cache_data_array (
    input wire logic clk,
    input wire cache_pkg::index_t set_index, // Set of the selected address
    input wire cache_pkg::offset_t word_offset, // Word inside the block
    input wire cache_pkg::word_t data_in, // Core data or DRAM return
    input wire logic write_data_array, // Store data_in on this edge

    output cache_pkg::word_t data_out // Word at set_index / word_offset
);

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // 256 words in total, no reset on the contents
    cache_pkg::word_t mem [`CACHE_SETS][`CACHE_BLOCK_WORDS];

    // One word per enabled edge
    always_ff @(posedge clk) begin
        if (write_data_array) begin
            mem[set_index][word_offset] <= data_in;
        end
    end

    // Asynchronous read, hit path stays inside one cycle
    assign data_out = mem[set_index][word_offset];

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // A write with an unknown location would smear the whole array
    // in simulation, so index and offset must resolve on every write
    write_location_known: assert property (
        @(posedge clk)
        write_data_array |-> !$isunknown({set_index, word_offset})
    ) else begin
        $error("data array written with unknown set or offset");
    end

endmodule

`default_nettype wire

// File: verilog/cache_tag_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

// Valid bits and tags, one entry per set, plus the hit compare
module cache_tag_array (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic enable, // Core request present
    input wire cache_pkg::index_t set_index, // Entry to compare or write
    input wire cache_pkg::tag_t tag, // Tag of the selected address
    input wire cache_pkg::tag_entry_t tag_in, // Valid plus tag from the fill FSM
    input wire logic write_tag_array, // Store tag_in at set_index

    output logic hit
);

    ////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////

    logic [`CACHE_SETS-1:0] valid_q; // Cleared by reset
    cache_pkg::tag_t tag_mem [`CACHE_SETS]; // Only meaningful when valid

    // Valid bits, reset leaves every set empty
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (write_tag_array) begin
            valid_q[set_index] <= tag_in[`CACHE_TAG_BITS]; // Top bit is valid
        end
    end

    // Tag field of the entry
    always_ff @(posedge clk) begin
        if (write_tag_array) begin
            tag_mem[set_index] <= tag_in[`CACHE_TAG_BITS-1:0];
        end
    end

    ////////////////////////////////////////
    // Hit compare
    ////////////////////////////////////////

    // Same-cycle answer to the core
    assign hit = enable & valid_q[set_index] & (tag_mem[set_index] == tag);

    // The fill FSM only ever installs a block, it never invalidates,
    // so an entry written without its valid bit points at a broken fill
    tag_write_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        write_tag_array |-> tag_in[`CACHE_TAG_BITS]
    ) else begin
        $error("tag entry written with valid bit clear");
    end

endmodule

`default_nettype wire

// File: verilog/cache_fill_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

// Miss handling that fetches one whole block from DRAM and then installs the tag
module cache_fill_control (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic enable, // Core request present
    input wire logic hit, // From the tag array
    input wire logic proceed, // DRAM access granted
    input wire cache_pkg::addr_t miss_address, // Core address held until hit
    input wire logic memory_data_valid, // One pulse per returned word

    output logic fsm_busy, // Fill path owns the arrays
    output logic miss_mem_en, // One DRAM word request per high cycle
    output cache_pkg::addr_t main_memory_address, // Address of the current request
    output cache_pkg::addr_t fill_address, // Where the returning word goes
    output cache_pkg::tag_entry_t fill_tag, // Entry written at the end of the fill
    output logic write_data_array, // Store the returning word
    output logic write_tag_array // Store fill_tag
);

    localparam int block_lsb = `CACHE_OFFSET_BITS + 1; // Offset plus byte bit
    localparam int block_bits = `CACHE_TAG_BITS + `CACHE_INDEX_BITS;
    localparam int cnt_bits = `CACHE_OFFSET_BITS + 1; // Counts 0 to 8

    // Count value of the eighth word
    localparam logic [cnt_bits-1:0] last_word = cnt_bits'(`CACHE_BLOCK_WORDS - 1);

    ////////////////////////////////////////
    // State and counters
    ////////////////////////////////////////

    cache_pkg::fill_state_t state_q, state_d;

    logic [block_bits-1:0] block_q; // Tag and index of the block being filled
    logic [cnt_bits-1:0] req_cnt_q; // Words requested so far
    logic [cnt_bits-1:0] ret_cnt_q; // Words returned so far

    logic start_fill; // Qualified miss in idle
    logic last_req; // Eighth request goes out this cycle
    logic last_ret; // Eighth word comes back this cycle

    assign start_fill = (state_q == cache_pkg::fill_idle) & enable & ~hit & proceed;

    // Requests only while proceed allows and the counter holds otherwise
    assign miss_mem_en = (state_q == cache_pkg::fill_request) & proceed;

    // Returns are accepted in both request and wait
    assign write_data_array = memory_data_valid &
                              ((state_q == cache_pkg::fill_request) |
                               (state_q == cache_pkg::fill_wait));

    assign write_tag_array = (state_q == cache_pkg::fill_tag); // Single cycle
    assign fsm_busy = (state_q != cache_pkg::fill_idle);

    assign last_req = miss_mem_en & (req_cnt_q == last_word);
    assign last_ret = write_data_array & (ret_cnt_q == last_word);

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::fill_idle: begin
                if (start_fill) begin
                    state_d = cache_pkg::fill_request;
                end
            end
            cache_pkg::fill_request: begin
                // A zero-latency DRAM can return the last word alongside its request
                if (last_req) begin
                    state_d = last_ret ? cache_pkg::fill_tag : cache_pkg::fill_wait;
                end
            end
            cache_pkg::fill_wait: begin
                if (last_ret) begin
                    state_d = cache_pkg::fill_tag;
                end
            end
            cache_pkg::fill_tag: begin
                state_d = cache_pkg::fill_idle; // Hit rises once back here
            end
            default: begin
                state_d = cache_pkg::fill_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= cache_pkg::fill_idle;
            req_cnt_q <= '0;
            ret_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == cache_pkg::fill_idle) begin
                req_cnt_q <= '0; // Fresh block on every fill
                ret_cnt_q <= '0;
            end else begin
                if (miss_mem_en) begin
                    req_cnt_q <= req_cnt_q + 1'b1;
                end
                if (write_data_array) begin
                    ret_cnt_q <= ret_cnt_q + 1'b1;
                end
            end
        end
    end

    // Block base captured once so the core address may change afterwards
    always_ff @(posedge clk) begin
        if (start_fill) begin
            block_q <= miss_address[`CACHE_WORD_BITS-1:block_lsb];
        end
    end

    ////////////////////////////////////////
    // Addresses and tag entry
    ////////////////////////////////////////

    // Base + 0, 2 .. 14
    assign main_memory_address = {block_q, req_cnt_q[`CACHE_OFFSET_BITS-1:0], 1'b0};
    assign fill_address = {block_q, ret_cnt_q[`CACHE_OFFSET_BITS-1:0], 1'b0}; // Word n at offset n

    assign fill_tag = {1'b1, block_q[block_bits-1 -: `CACHE_TAG_BITS]};

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Requests also stop once the whole block has been asked for
    no_request_without_proceed: assert property (
        @(posedge clk) disable iff (!rst_n)
        miss_mem_en |-> proceed && (req_cnt_q < `CACHE_BLOCK_WORDS)
    ) else begin
        $error("DRAM request issued while proceed is low or after the last word");
    end

    // DRAM only answers requests and all of them land before fill_tag
    no_return_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        memory_data_valid |-> (state_q != cache_pkg::fill_idle)
    ) else begin
        $error("memory_data_valid with no fill in progress");
    end

    in_flight_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ret_cnt_q <= req_cnt_q) && ((req_cnt_q - ret_cnt_q) <= `CACHE_BLOCK_WORDS)
    ) else begin
        $error("request and return counters out of step");
    end

endmodule

`default_nettype wire

// File: verilog/memory_system.sv
`timescale 1ns/100ps
`default_nettype none

`include "cache_settings.svh"

// L1 data memory, direct-mapped cache in front of off-chip DRAM
module memory_system (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic enable, // Core request present
    input wire logic proceed, // DRAM access granted, fills stall while low
    input wire logic on_chip_wr, // Core write
    input wire cache_pkg::addr_t on_chip_memory_address, // Core address, also the miss address
    input wire cache_pkg::word_t on_chip_memory_data, // Core write data

    // DRAM side
    input wire cache_pkg::word_t off_chip_memory_data, // Returned word
    input wire logic memory_data_valid, // Returned word is valid
    output cache_pkg::addr_t off_chip_memory_address, // Requested word address
    output logic miss_mem_en, // Word request strobe

    output cache_pkg::word_t data_out, // Read data, valid with hit
    output logic hit
);

    localparam int offset_lsb = 1; // Bit 0 selects a byte, ignored
    localparam int index_lsb = offset_lsb + `CACHE_OFFSET_BITS;
    localparam int tag_lsb = index_lsb + `CACHE_INDEX_BITS;

    ////////////////////////////////////////
    // Internal signals
    ////////////////////////////////////////

    logic fsm_busy; // Fill in progress
    logic write_data_array; // Fill word write
    logic write_tag_array; // Fill tag write
    cache_pkg::addr_t fill_address; // Cache location of the returning word
    cache_pkg::tag_entry_t fill_tag;

    cache_pkg::addr_t addr; // Address presented to the arrays
    cache_pkg::word_t data_in; // Data presented to the data array
    logic wr_data_enable;

    // Fill path owns the arrays while busy
    assign addr = fsm_busy ? fill_address : on_chip_memory_address;
    assign data_in = fsm_busy ? off_chip_memory_data : on_chip_memory_data;

    // Core writes only land on a hit, DRAM never sees them
    assign wr_data_enable = fsm_busy ? write_data_array : (on_chip_wr & hit);

    ////////////////////////////////////////
    // Arrays
    ////////////////////////////////////////

    cache_data_array data_array_inst (
        .clk(clk),
        .set_index(addr[index_lsb +: `CACHE_INDEX_BITS]),
        .word_offset(addr[offset_lsb +: `CACHE_OFFSET_BITS]),
        .data_in(data_in),
        .write_data_array(wr_data_enable),
        .data_out(data_out)
    );

    cache_tag_array tag_array_inst (
        .clk(clk),
        .rst_n(rst_n),
        .enable(enable),
        .set_index(addr[index_lsb +: `CACHE_INDEX_BITS]),
        .tag(addr[tag_lsb +: `CACHE_TAG_BITS]),
        .tag_in(fill_tag),
        .write_tag_array(write_tag_array), // No rewrite on hits, single way
        .hit(hit)
    );

    ////////////////////////////////////////
    // Fill controller
    ////////////////////////////////////////

    cache_fill_control fill_control_inst (
        .clk(clk),
        .rst_n(rst_n),
        .enable(enable),
        .hit(hit), // Miss formed inside from enable and hit
        .proceed(proceed),
        .miss_address(on_chip_memory_address),
        .memory_data_valid(memory_data_valid),
        .fsm_busy(fsm_busy),
        .miss_mem_en(miss_mem_en),
        .main_memory_address(off_chip_memory_address),
        .fill_address(fill_address),
        .fill_tag(fill_tag),
        .write_data_array(write_data_array),
        .write_tag_array(write_tag_array)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/100ps

// Free-running bench clock
module tb_clock_gen (
    output logic clk
);

    localparam realtime half_period = 2.0; // 4 ns period

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

// File: bench/dram_model.sv
`timescale 1ns/100ps

// Behavioral DRAM, answers every request a fixed number of cycles later
module dram_model #(
    parameter int read_latency = 3 // Request edge to valid edge, at least 2
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic miss_mem_en, // One word request per high cycle
    input wire cache_pkg::addr_t address,
    output cache_pkg::word_t read_data, // Address XOR 5A5A
    output logic data_valid // One pulse per returned word
);

    logic [read_latency-1:0] valid_pipe; // Requests in flight
    cache_pkg::addr_t addr_pipe [read_latency];

    initial begin
        read_data = '0;
        data_valid = 1'b0;
    end

    // Requests sampled on the rising edge, same as the cache sees them
    always @(posedge clk) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[read_latency-2:0], miss_mem_en};
        end
        addr_pipe[0] <= address;
        for (int i = 1; i < read_latency; i++) begin
            addr_pipe[i] <= addr_pipe[i-1]; // Keeps request order
        end
    end

    // Returns driven on the falling edge
    always @(negedge clk) begin
        data_valid <= rst_n & valid_pipe[read_latency-1];
        read_data <= valid_pipe[read_latency-1] ? (addr_pipe[read_latency-1] ^ 16'h5A5A) : '0;
    end

endmodule

// File: bench/tb_memory_system.sv
`timescale 1ns/100ps

`include "cache_settings.svh"

module tb_memory_system;

    localparam int index_lsb = 1 + `CACHE_OFFSET_BITS; // Byte bit plus word offset
    localparam int tag_lsb = index_lsb + `CACHE_INDEX_BITS;
    localparam int hit_wait_limit = 40; // Fill with proceed toggling, plus margin
    localparam int run_limit = 2000; // Whole run, all fills at worst case

    logic clk;
    logic rst_n;
    logic enable;
    logic proceed;
    logic on_chip_wr;
    cache_pkg::addr_t on_chip_memory_address;
    cache_pkg::word_t on_chip_memory_data;
    cache_pkg::word_t off_chip_memory_data; // From the DRAM model
    logic memory_data_valid;
    cache_pkg::addr_t off_chip_memory_address;
    logic miss_mem_en;
    cache_pkg::word_t data_out;
    logic hit;

    // Shadow of resident tags and block contents
    logic shadow_valid [`CACHE_SETS];
    cache_pkg::tag_t shadow_tag [`CACHE_SETS];
    cache_pkg::word_t shadow_data [`CACHE_SETS][`CACHE_BLOCK_WORDS];

    cache_pkg::addr_t request_log [$]; // DRAM requests of the current access
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    integer seed = 8;

    tb_clock_gen clock_inst (.clk(clk));

    dram_model #(.read_latency(3)) dram_inst (
        .clk(clk),
        .rst_n(rst_n),
        .miss_mem_en(miss_mem_en),
        .address(off_chip_memory_address),
        .read_data(off_chip_memory_data),
        .data_valid(memory_data_valid)
    );

    memory_system memory_system_inst (
        .clk(clk),
        .rst_n(rst_n),
        .enable(enable),
        .proceed(proceed),
        .on_chip_wr(on_chip_wr),
        .on_chip_memory_address(on_chip_memory_address),
        .on_chip_memory_data(on_chip_memory_data),
        .off_chip_memory_data(off_chip_memory_data),
        .memory_data_valid(memory_data_valid),
        .off_chip_memory_address(off_chip_memory_address),
        .miss_mem_en(miss_mem_en),
        .data_out(data_out),
        .hit(hit)
    );

    ////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_n === 1'b1 && miss_mem_en === 1'b1) begin
            request_log.push_back(off_chip_memory_address); // One word per strobe
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == run_limit) begin
            $display("Timeout: run passed %0d cycles without finishing", run_limit);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("Errors found");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check(input string name, input logic [15:0] actual,
                         input logic [15:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic cache_pkg::word_t dram_word(input cache_pkg::addr_t address);
        return address ^ 16'h5A5A; // DRAM data pattern
    endfunction

    task automatic wait_for_hit(output bit got_hit, output int cycles);
        cycles = 0;
        got_hit = 1'b0;
        while (!got_hit && cycles < hit_wait_limit) begin
            @(posedge clk);
            cycles++;
            got_hit = (hit === 1'b1); // Pre-edge value, stable
        end
    endtask

    // Drop and raise proceed every cycle through the request burst
    task automatic toggle_proceed_burst();
        repeat (12) begin
            @(negedge clk);
            proceed = ~proceed;
        end
        proceed = 1'b1;
    endtask

    // One core request, held until hit, checked against the shadow
    task automatic access(input cache_pkg::addr_t address, input logic write,
                          input cache_pkg::word_t wdata, input int stall_cycles,
                          input bit toggle);
        cache_pkg::index_t idx;
        cache_pkg::tag_t tag;
        cache_pkg::offset_t off;
        cache_pkg::addr_t base;
        bit resident;
        bit got_hit;
        int cycles;
        idx = address[index_lsb +: `CACHE_INDEX_BITS];
        tag = address[tag_lsb +: `CACHE_TAG_BITS];
        off = address[1 +: `CACHE_OFFSET_BITS];
        base = address & 16'hFFF0; // Block base, 16 bytes
        resident = shadow_valid[idx] && (shadow_tag[idx] == tag);
        @(negedge clk);
        request_log.delete();
        enable = 1'b1;
        on_chip_wr = write;
        on_chip_memory_address = address;
        on_chip_memory_data = wdata;
        proceed = (stall_cycles == 0); // No DRAM grant while stalled
        repeat (stall_cycles) begin
            @(posedge clk);
            check("miss_mem_en", miss_mem_en, 1'b0);
            check("hit", hit, resident);
        end
        if (stall_cycles > 0) begin
            @(negedge clk);
            proceed = 1'b1;
        end
        fork
            wait_for_hit(got_hit, cycles);
            if (toggle) toggle_proceed_burst();
        join
        if (!got_hit) begin
            $display("Request to %h: hit did not rise within %0d cycles", address, hit_wait_limit);
            error_count++;
        end else begin
            check("hit", (cycles == 1), resident); // Same-cycle hit only if resident
            if (!resident) begin
                // Whole block fetched in address order
                check("miss_mem_en count", request_log.size(), `CACHE_BLOCK_WORDS);
                for (int k = 0; k < `CACHE_BLOCK_WORDS; k++) begin
                    shadow_data[idx][k] = dram_word(base + 2 * k);
                    if (k < request_log.size()) begin
                        check("off_chip_memory_address", request_log[k], base + 2 * k);
                    end
                end
                shadow_valid[idx] = 1'b1;
                shadow_tag[idx] = tag;
            end else begin
                check("miss_mem_en count", request_log.size(), 0);
            end
            if (write) shadow_data[idx][off] = wdata; // Landed on the hit edge
            else check("data_out", data_out, shadow_data[idx][off]);
        end
        @(negedge clk);
        enable = 1'b0;
        on_chip_wr = 1'b0;
    endtask

    task automatic read_block(input cache_pkg::addr_t base, input bit toggle);
        access(base, 1'b0, '0, 0, toggle); // Miss and fill
        for (int k = 1; k < `CACHE_BLOCK_WORDS; k++) begin
            access(base + 2 * k, 1'b0, '0, 0, 1'b0); // Rest of the block hits
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_miss();
        cache_pkg::addr_t address;
        address = $random(seed);
        access(address, 1'b0, '0, 0, 1'b0); // Cold cache, must miss
    endtask

    task automatic test_write();
        access(16'h2A48, 1'b1, 16'hBEEF, 0, 1'b0); // Resident block
        access(16'h2A48, 1'b0, '0, 0, 1'b0);
        access(16'h7F1C, 1'b1, 16'h1357, 0, 1'b0); // Fill first, then store
        access(16'h7F1C, 1'b0, '0, 0, 1'b0);
        access(16'h7F12, 1'b0, '0, 0, 1'b0);
    endtask

    task automatic test_eviction();
        access(16'h2A46, 1'b1, 16'hCAFE, 0, 1'b0);
        access(16'h2C46, 1'b0, '0, 0, 1'b0); // Same set, other tag
        access(16'h2A46, 1'b0, '0, 0, 1'b0); // Written word lost
    endtask

    task automatic test_proceed();
        access(16'h4C32, 1'b0, '0, 20, 1'b0); // Grant withheld for 20 cycles
        read_block(16'h5D70, 1'b1); // Grant toggling during the burst
    endtask

    task automatic test_random_mix();
        cache_pkg::addr_t bases [4] = '{16'h2A40, 16'h2C40, 16'h0890, 16'h6E20};
        logic [31:0] r;
        repeat (40) begin
            r = $random(seed);
            access(bases[r[1:0]] | {r[4:2], 1'b0}, r[5], r[31:16], 0, 1'b0);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        enable = 1'b0;
        proceed = 1'b1;
        on_chip_wr = 1'b0;
        on_chip_memory_address = '0;
        on_chip_memory_data = '0;
        for (int s = 0; s < `CACHE_SETS; s++) shadow_valid[s] = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        test_reset_miss();
        read_block(16'h2A40, 1'b0);
        test_write();
        test_eviction();
        test_proceed();
        test_random_mix();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_data_array.sv
verilog/cache_tag_array.sv
verilog/cache_fill_control.sv
verilog/memory_system.sv
bench/tb_clock_gen.sv
bench/dram_model.sv
bench/tb_memory_system.sv

// File: Bender.yml
package:
  name: memory_system

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_pkg.sv
      - verilog/cache_data_array.sv
      - verilog/cache_tag_array.sv
      - verilog/cache_fill_control.sv
      - verilog/memory_system.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/tb_clock_gen.sv
      - bench/dram_model.sv
      - bench/tb_memory_system.sv
